//--- design/memStagePkg.sv
////////////////////
// memory stage package
// opcodes, access widths and the stage's bundles
////////////////////
`default_nettype none

package memStagePkg;

    // width of the time-to-result counter
    localparam int TNEW_W = 2;

    // load opcodes
    localparam logic [5:0] OP_LB  = 6'h20;
    localparam logic [5:0] OP_LH  = 6'h21;
    localparam logic [5:0] OP_LW  = 6'h23;
    localparam logic [5:0] OP_LBU = 6'h24;
    localparam logic [5:0] OP_LHU = 6'h25;

    // store opcodes
    localparam logic [5:0] OP_SB  = 6'h28;
    localparam logic [5:0] OP_SH  = 6'h29;
    localparam logic [5:0] OP_SW  = 6'h2b;

    // size of one memory access
    typedef enum logic [1:0] {
        widthByte = 2'd0,
        widthHalf = 2'd1,
        widthWord = 2'd2
    } accessWidthT;

    // I-type view of an instruction word
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } instrFieldsT;

    // decoded memory control
    typedef struct packed {
        logic        isLoad;
        logic        isStore;
        accessWidthT width;
        // sign extension on loads only
        logic        signExt;
    } memCtrlT;

    // EX/MEM pipeline bundle
    typedef struct packed {
        instrFieldsT       instr;
        logic [31:0]       pc;
        logic [31:0]       aluOut;
        logic [31:0]       rtData;
        logic [31:0]       regWriteData;
        logic [4:0]        rtAddr;
        logic [4:0]        regWriteAddr;
        logic [TNEW_W-1:0] tNew;
    } memInT;

    // value being written back by WB this cycle
    typedef struct packed {
        logic [4:0]  addr;
        logic [31:0] data;
    } wbFwdT;

    // MEM/WB pipeline register contents
    typedef struct packed {
        instrFieldsT instr;
        logic [31:0] pc;
        logic [31:0] memReadData;
        // zero means no writeback
        logic [4:0]  regWriteAddr;
        logic [31:0] regWriteData;
    } wbOutT;

endpackage

`default_nettype wire

//--- design/instrClassify.sv
////////////////////
// instruction classifier
// opcode to load/store, width and extension
////////////////////
`default_nettype none
`timescale 1ns/100ps

module instrClassify
    import memStagePkg::*;
(
    input  instrFieldsT instr,
    output memCtrlT     ctrl
);

    always_comb begin
        // non-memory by default
        ctrl.isLoad  = 1'b0;
        ctrl.isStore = 1'b0;
        ctrl.width   = widthWord;
        ctrl.signExt = 1'b0;

        case (instr.opcode)
            // signed loads
            OP_LB: begin
                ctrl.isLoad  = 1'b1;
                ctrl.width   = widthByte;
                ctrl.signExt = 1'b1;
            end
            OP_LH: begin
                ctrl.isLoad  = 1'b1;
                ctrl.width   = widthHalf;
                ctrl.signExt = 1'b1;
            end
            OP_LW: begin
                ctrl.isLoad  = 1'b1;
                ctrl.width   = widthWord;
            end
            // unsigned loads
            OP_LBU: begin
                ctrl.isLoad  = 1'b1;
                ctrl.width   = widthByte;
            end
            OP_LHU: begin
                ctrl.isLoad  = 1'b1;
                ctrl.width   = widthHalf;
            end
            // stores never extend
            OP_SB: begin
                ctrl.isStore = 1'b1;
                ctrl.width   = widthByte;
            end
            OP_SH: begin
                ctrl.isStore = 1'b1;
                ctrl.width   = widthHalf;
            end
            OP_SW: begin
                ctrl.isStore = 1'b1;
                ctrl.width   = widthWord;
            end
            default: begin
                // alu, branch and the rest pass through
                ctrl.isLoad  = 1'b0;
                ctrl.isStore = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/memAccess.sv
////////////////////
// data memory access
// store forwarding, lane write, extended load
////////////////////
`default_nettype none
`timescale 1ns/100ps

module memAccess
    import memStagePkg::*;
#(
    parameter int MEM_WORDS = 1024
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        stall,
    input  logic        clr,
    input  memCtrlT     ctrl,
    input  memInT       memIn,
    input  wbFwdT       wbFwd,
    output logic [31:0] readData
);

    localparam int ADDR_W = $clog2(MEM_WORDS);

    // word-organized data memory, no reset
    logic [31:0]       mem [MEM_WORDS];

    logic [31:0]       fwdData;
    logic [ADDR_W-1:0] wordIdx;
    logic [1:0]        byteOff;
    logic [3:0]        wrMask;
    logic [31:0]       wrData;
    logic              wrEn;
    logic [31:0]       rdWord;
    logic [7:0]        rdByte;
    logic [15:0]       rdHalf;

    // WB result overrides a stale rt, r0 never forwards
    assign fwdData = (wbFwd.addr == memIn.rtAddr && wbFwd.addr != 5'd0) ?
                     wbFwd.data : memIn.rtData;

    // word index wraps at MEM_WORDS
    assign wordIdx = ADDR_W'(memIn.aluOut[31:2] % 30'(MEM_WORDS));
    assign byteOff = memIn.aluOut[1:0];

    // no write while stalled, cleared or in reset
    assign wrEn = ctrl.isStore && !stall && !clr && rstN;

    // lane mask and shifted store data
    always_comb begin
        case (ctrl.width)
            widthByte: begin
                wrMask = 4'b0001 << byteOff;
                wrData = {24'd0, fwdData[7:0]} << {byteOff, 3'b000};
            end
            widthHalf: begin
                // upper or lower half by bit 1
                wrMask = memIn.aluOut[1] ? 4'b1100 : 4'b0011;
                wrData = memIn.aluOut[1] ? {fwdData[15:0], 16'd0} :
                                           {16'd0, fwdData[15:0]};
            end
            default: begin
                wrMask = 4'b1111;
                wrData = fwdData;
            end
        endcase
    end

    // byte-enabled write at end of cycle
    always_ff @(posedge clk) begin
        if (wrEn) begin
            for (int i = 0; i < 4; i++) begin
                if (wrMask[i]) begin
                    mem[wordIdx][i*8 +: 8] <= wrData[i*8 +: 8];
                end
            end
        end
    end

    // asynchronous read
    assign rdWord = mem[wordIdx];
    assign rdByte = rdWord[{byteOff, 3'b000} +: 8];
    assign rdHalf = memIn.aluOut[1] ? rdWord[31:16] : rdWord[15:0];

    // lane extract and extend, zero when not a load
    always_comb begin
        if (!ctrl.isLoad) begin
            readData = 32'd0;
        end else begin
            case (ctrl.width)
                widthByte: readData = {{24{ctrl.signExt & rdByte[7]}}, rdByte};
                widthHalf: readData = {{16{ctrl.signExt & rdHalf[15]}}, rdHalf};
                default:   readData = rdWord;
            endcase
        end
    end

    // halfword accesses on even addresses
    assert property (@(posedge clk) disable iff (!rstN)
        (ctrl.isLoad || ctrl.isStore) && ctrl.width == widthHalf
        |-> memIn.aluOut[0] == 1'b0)
        else $error("memAccess: misaligned halfword at %h", memIn.aluOut);

    // word accesses on multiples of four
    assert property (@(posedge clk) disable iff (!rstN)
        (ctrl.isLoad || ctrl.isStore) && ctrl.width == widthWord
        |-> memIn.aluOut[1:0] == 2'b00)
        else $error("memAccess: misaligned word at %h", memIn.aluOut);

endmodule

`default_nettype wire

//--- design/memWbReg.sv
////////////////////
// MEM/WB pipeline register
// writeback select, tNew decrement, stall and clear
////////////////////
`default_nettype none
`timescale 1ns/100ps

module memWbReg
    import memStagePkg::*;
(
    input  logic              clk,
    input  logic              rstN,
    input  logic              stall,
    input  logic              clr,
    input  memCtrlT           ctrl,
    input  memInT             memIn,
    input  logic [31:0]       readData,
    output wbOutT             wbOut,
    output logic [TNEW_W-1:0] tNewOut
);

    logic [31:0] wbData;
    wbOutT       wbNext;

    // loads write back memory data and others keep the EX result
    assign wbData = ctrl.isLoad ? readData : memIn.regWriteData;

    // one stage closer to the result and floored at zero
    assign tNewOut = (memIn.tNew != '0) ? memIn.tNew - TNEW_W'(1) : '0;

    // next register contents
    always_comb begin
        wbNext.instr        = memIn.instr;
        wbNext.pc           = memIn.pc;
        wbNext.memReadData  = readData;
        wbNext.regWriteAddr = memIn.regWriteAddr;
        wbNext.regWriteData = wbData;
    end

    // stall wins over clr since clr only empties a moving stage
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbOut <= '0;
        end else if (!stall) begin
            if (clr) begin
                wbOut <= '0;
            end else begin
                wbOut <= wbNext;
            end
        end
    end

    // stalled register keeps its contents across the edge
    assert property (@(posedge clk)
        stall && rstN |=> wbOut == $past(wbOut))
        else $error("memWbReg: wbOut changed under stall");

endmodule

`default_nettype wire

//--- design/memStage.sv
////////////////////
// memory access stage top level
// classifier, data memory and MEM/WB register
////////////////////
`default_nettype none
`timescale 1ns/100ps

module memStage
    import memStagePkg::*;
#(
    parameter int MEM_WORDS = 1024
) (
    input  logic              clk,
    input  logic              rstN,
    // pipeline control levels
    input  logic              stall,
    input  logic              clr,
    // EX/MEM bundle
    input  memInT             memIn,
    // value WB is writing this cycle
    input  wbFwdT             wbFwd,
    // to WB stage
    output wbOutT             wbOut,
    // to hazard unit
    output logic [TNEW_W-1:0] tNewOut
);

    // decoded load/store control
    memCtrlT     ctrl;
    // extended load data
    logic [31:0] readData;

    // opcode decode
    instrClassify i_instrClassify (
        .instr (memIn.instr),
        .ctrl  (ctrl)
    );

    // forwarding and memory array
    memAccess #(
        .MEM_WORDS (MEM_WORDS)
    ) i_memAccess (
        .clk      (clk),
        .rstN     (rstN),
        .stall    (stall),
        .clr      (clr),
        .ctrl     (ctrl),
        .memIn    (memIn),
        .wbFwd    (wbFwd),
        .readData (readData)
    );

    // result select and pipeline register
    memWbReg i_memWbReg (
        .clk      (clk),
        .rstN     (rstN),
        .stall    (stall),
        .clr      (clr),
        .ctrl     (ctrl),
        .memIn    (memIn),
        .readData (readData),
        .wbOut    (wbOut),
        .tNewOut  (tNewOut)
    );

endmodule

`default_nettype wire

//--- tests/memStageTb.sv
////////////////////
// memory stage testbench
// directed tests against a word-array reference model
////////////////////
`default_nettype none
`timescale 1ns/100ps

module memStageTb
    import memStagePkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int MEM_WORDS  = 256;
    localparam int IDX_W      = $clog2(MEM_WORDS);
    // upper bound on ops over all tests at two cycles each
    localparam int MAX_OPS    = 64;
    localparam int TIMEOUT_NS = (2 + 2 * MAX_OPS + 20) * CLK_PERIOD;
    localparam wbFwdT NO_FWD  = '0;

    logic              clk;
    logic              rstN;
    logic              stall;
    logic              clr;
    memInT             memIn;
    wbFwdT             wbFwd;
    wbOutT             wbOut;
    logic [TNEW_W-1:0] tNewOut;

    // reference copy of the data memory
    logic [31:0] refMem [MEM_WORDS];
    wbOutT       lastWb;
    logic [31:0] pcCount;
    int          errCount;
    int          checkCount;

    memStage #(
        .MEM_WORDS (MEM_WORDS)
    ) i_memStage (
        .clk     (clk),
        .rstN    (rstN),
        .stall   (stall),
        .clr     (clr),
        .memIn   (memIn),
        .wbFwd   (wbFwd),
        .wbOut   (wbOut),
        .tNewOut (tNewOut)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // word index wraps at the memory size
    function automatic logic [IDX_W-1:0] wordIndex(input logic [31:0] addr);
        return IDX_W'((addr >> 2) % MEM_WORDS);
    endfunction

    // opcode table from the ISA
    function automatic memCtrlT decodeOp(input logic [5:0] op);
        memCtrlT c;
        c = '{1'b0, 1'b0, widthWord, 1'b0};
        case (op)
            OP_LB:  c = '{1'b1, 1'b0, widthByte, 1'b1};
            OP_LH:  c = '{1'b1, 1'b0, widthHalf, 1'b1};
            OP_LW:  c = '{1'b1, 1'b0, widthWord, 1'b0};
            OP_LBU: c = '{1'b1, 1'b0, widthByte, 1'b0};
            OP_LHU: c = '{1'b1, 1'b0, widthHalf, 1'b0};
            OP_SB:  c = '{1'b0, 1'b1, widthByte, 1'b0};
            OP_SH:  c = '{1'b0, 1'b1, widthHalf, 1'b0};
            OP_SW:  c = '{1'b0, 1'b1, widthWord, 1'b0};
            default: c = '{1'b0, 1'b0, widthWord, 1'b0};
        endcase
        return c;
    endfunction

    // expected load value with the lane picked by the low address bits
    function automatic logic [31:0] modelLoad(input logic [31:0] addr,
                                              input accessWidthT width, input logic signExt);
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        word = refMem[wordIndex(addr)];
        b = word[{addr[1:0], 3'b000} +: 8];
        h = word[{addr[1], 4'b0000} +: 16];
        case (width)
            widthByte: return {{24{signExt & b[7]}}, b};
            widthHalf: return {{16{signExt & h[15]}}, h};
            default:   return word;
        endcase
    endfunction

    // only the addressed lanes change
    function automatic void modelStore(input logic [31:0] addr, input accessWidthT width,
                                       input logic [31:0] data);
        logic [IDX_W-1:0] idx;
        idx = wordIndex(addr);
        case (width)
            widthByte: refMem[idx][{addr[1:0], 3'b000} +: 8] = data[7:0];
            widthHalf: refMem[idx][{addr[1], 4'b0000} +: 16] = data[15:0];
            default:   refMem[idx] = data;
        endcase
    endfunction

    // I-type op with random rs and tNew
    function automatic memInT makeOp(input logic [5:0] op, input logic [31:0] addr,
                                     input logic [4:0] rtAddr, input logic [31:0] rtData,
                                     input logic [4:0] rdAddr, input logic [31:0] rdData);
        memInT m;
        m.instr.opcode  = op;
        m.instr.rs      = 5'($urandom);
        m.instr.rt      = rtAddr;
        m.instr.imm     = addr[15:0];
        m.pc            = '0;
        m.aluOut        = addr;
        m.rtData        = rtData;
        m.regWriteData  = rdData;
        m.rtAddr        = rtAddr;
        m.regWriteAddr  = rdAddr;
        m.tNew          = 2'($urandom);
        return m;
    endfunction

    task automatic checkVal(input string sigName, input logic [31:0] expVal,
                            input logic [31:0] actVal);
        checkCount++;
        if (actVal !== expVal) begin
            $display("error at %0t ns: %s expected %h, got %h", $time, sigName, expVal, actVal);
            errCount++;
        end
    endtask

    task automatic checkWb(input wbOutT expWb);
        checkVal("wbOut.instr", expWb.instr, wbOut.instr);
        checkVal("wbOut.pc", expWb.pc, wbOut.pc);
        checkVal("wbOut.memReadData", expWb.memReadData, wbOut.memReadData);
        checkVal("wbOut.regWriteAddr", 32'(expWb.regWriteAddr), 32'(wbOut.regWriteAddr));
        checkVal("wbOut.regWriteData", expWb.regWriteData, wbOut.regWriteData);
    endtask

    // drive one op and check tNewOut, then freeze after the capture edge and check wbOut
    task automatic runOp(input memInT opIn, input wbFwdT fwd, input logic stallIn,
                         input logic clrIn);
        memInT             cur;
        memCtrlT           c;
        wbOutT             expWb;
        logic [31:0]       storeData;
        logic [TNEW_W-1:0] expT;
        cur = opIn;
        cur.pc = pcCount;
        pcCount = pcCount + 32'd4;
        c = decodeOp(cur.instr.opcode);
        @(posedge clk);
        memIn <= cur;
        wbFwd <= fwd;
        stall <= stallIn;
        clr   <= clrIn;
        @(negedge clk);
        // saturating decrement
        expT = (cur.tNew == 2'd0) ? 2'd0 : cur.tNew - 2'd1;
        checkVal("tNewOut", 32'(expT), 32'(tNewOut));
        expWb.instr        = cur.instr;
        expWb.pc           = cur.pc;
        expWb.memReadData  = c.isLoad ? modelLoad(cur.aluOut, c.width, c.signExt) : 32'd0;
        expWb.regWriteAddr = cur.regWriteAddr;
        expWb.regWriteData = c.isLoad ? expWb.memReadData : cur.regWriteData;
        if (stallIn) begin
            expWb = lastWb;
        end else if (clrIn) begin
            expWb = '0;
        end
        // store lands only when the stage moves
        if (c.isStore && !stallIn && !clrIn) begin
            storeData = (fwd.addr == cur.rtAddr && fwd.addr != 5'd0) ? fwd.data : cur.rtData;
            modelStore(cur.aluOut, c.width, storeData);
        end
        @(posedge clk);
        // hold the stage until the next op
        stall <= 1'b1;
        clr   <= 1'b0;
        @(negedge clk);
        checkWb(expWb);
        lastWb = expWb;
    endtask

    task automatic resetTest();
        wbOutT zeroWb;
        zeroWb = '0;
        checkWb(zeroWb);
        // tNew held at 3 during reset
        checkVal("tNewOut", 32'd2, 32'(tNewOut));
    endtask

    task automatic wordTest();
        logic [31:0] addrs [8];
        for (int i = 0; i < 8; i++) begin
            addrs[i] = $urandom & 32'hffff_fffc;
            runOp(makeOp(OP_SW, addrs[i], 5'($urandom), $urandom, 5'd0, $urandom),
                  NO_FWD, 1'b0, 1'b0);
        end
        // read back with regWriteAddr 1..8
        for (int i = 0; i < 8; i++) begin
            runOp(makeOp(OP_LW, addrs[i], 5'd0, $urandom, 5'(i + 1), $urandom),
                  NO_FWD, 1'b0, 1'b0);
        end
    endtask

    task automatic byteHalfTest();
        logic [31:0] base;
        base = 32'h0000_0140;
        runOp(makeOp(OP_SW, base, 5'd3, 32'h1234_5678, 5'd0, 32'd0), NO_FWD, 1'b0, 1'b0);
        // negative bytes into lanes 0 and 3
        runOp(makeOp(OP_SB, base, 5'd3, 32'h0000_00a5, 5'd0, 32'd0), NO_FWD, 1'b0, 1'b0);
        runOp(makeOp(OP_SB, base + 32'd3, 5'd3, 32'hffff_ff9c, 5'd0, 32'd0),
              NO_FWD, 1'b0, 1'b0);
        runOp(makeOp(OP_LW, base, 5'd0, 32'd0, 5'd9, 32'd0), NO_FWD, 1'b0, 1'b0);
        checkVal("wbOut.memReadData", 32'h9c34_56a5, wbOut.memReadData);
        for (int i = 0; i < 4; i++) begin
            runOp(makeOp(OP_LB, base + 32'(i), 5'd0, 32'd0, 5'd10, 32'd0), NO_FWD, 1'b0, 1'b0);
            runOp(makeOp(OP_LBU, base + 32'(i), 5'd0, 32'd0, 5'd11, 32'd0), NO_FWD, 1'b0, 1'b0);
        end
        // negative half into the upper lane
        runOp(makeOp(OP_SH, base + 32'd2, 5'd3, 32'h0000_8001, 5'd0, 32'd0), NO_FWD, 1'b0, 1'b0);
        runOp(makeOp(OP_LW, base, 5'd0, 32'd0, 5'd9, 32'd0), NO_FWD, 1'b0, 1'b0);
        for (int i = 0; i < 2; i++) begin
            runOp(makeOp(OP_LH, base + 32'(2 * i), 5'd0, 32'd0, 5'd12, 32'd0), NO_FWD, 1'b0, 1'b0);
            runOp(makeOp(OP_LHU, base + 32'(2 * i), 5'd0, 32'd0, 5'd13, 32'd0),
                  NO_FWD, 1'b0, 1'b0);
        end
    endtask

    task automatic fwdTest();
        wbFwdT fwd;
        // WB writes r5 while the store reads r5
        fwd.addr = 5'd5;
        fwd.data = 32'hcafe_f00d;
        runOp(makeOp(OP_SW, 32'h200, 5'd5, 32'h1111_1111, 5'd0, 32'd0), fwd, 1'b0, 1'b0);
        runOp(makeOp(OP_LW, 32'h200, 5'd0, 32'd0, 5'd7, 32'd0), NO_FWD, 1'b0, 1'b0);
        checkVal("wbOut.memReadData", 32'hcafe_f00d, wbOut.memReadData);
        // r0 never forwards
        fwd.addr = 5'd0;
        runOp(makeOp(OP_SW, 32'h204, 5'd0, 32'h2222_2222, 5'd0, 32'd0), fwd, 1'b0, 1'b0);
        runOp(makeOp(OP_LW, 32'h204, 5'd0, 32'd0, 5'd7, 32'd0), NO_FWD, 1'b0, 1'b0);
        checkVal("wbOut.memReadData", 32'h2222_2222, wbOut.memReadData);
        // WB target differs from rt
        fwd.addr = 5'd6;
        runOp(makeOp(OP_SW, 32'h208, 5'd5, 32'h3333_3333, 5'd0, 32'd0), fwd, 1'b0, 1'b0);
        runOp(makeOp(OP_LW, 32'h208, 5'd0, 32'd0, 5'd7, 32'd0), NO_FWD, 1'b0, 1'b0);
        checkVal("wbOut.memReadData", 32'h3333_3333, wbOut.memReadData);
    endtask

    task automatic nonMemTest();
        memInT m;
        // ALU-type opcode aimed at a stored word with tNew 0..3
        for (int t = 0; t < 4; t++) begin
            m = makeOp(6'h00, 32'h200, 5'd5, 32'hdead_beef, 5'(t + 12), $urandom);
            m.tNew = 2'(t);
            runOp(m, NO_FWD, 1'b0, 1'b0);
        end
        runOp(makeOp(OP_LW, 32'h200, 5'd0, 32'd0, 5'd7, 32'd0), NO_FWD, 1'b0, 1'b0);
        checkVal("wbOut.memReadData", 32'hcafe_f00d, wbOut.memReadData);
    endtask

    task automatic stallClearTest();
        runOp(makeOp(OP_LW, 32'h204, 5'd0, 32'd0, 5'd8, 32'd0), NO_FWD, 1'b0, 1'b0);
        // stalled store leaves wbOut on the load
        runOp(makeOp(OP_SW, 32'h204, 5'd4, 32'h5555_aaaa, 5'd0, 32'd0), NO_FWD, 1'b1, 1'b0);
        // cleared store empties wbOut
        runOp(makeOp(OP_SW, 32'h204, 5'd4, 32'h6666_9999, 5'd0, 32'd0), NO_FWD, 1'b0, 1'b1);
        runOp(makeOp(OP_LW, 32'h204, 5'd0, 32'd0, 5'd9, 32'd0), NO_FWD, 1'b0, 1'b0);
        checkVal("wbOut.memReadData", 32'h2222_2222, wbOut.memReadData);
    endtask

    initial begin
        void'($urandom(32'h442ad01e));
        errCount    = 0;
        checkCount  = 0;
        pcCount     = 32'h0040_0000;
        lastWb      = '0;
        rstN        <= 1'b0;
        stall       <= 1'b0;
        clr         <= 1'b0;
        wbFwd       <= '0;
        memIn       <= '0;
        memIn.tNew  <= 2'd3;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        resetTest();
        wordTest();
        byteHalfTest();
        fwdTest();
        nonMemTest();
        stallClearTest();
        $display("tests done: %0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: tests still running after %0d ns", TIMEOUT_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
design/memStagePkg.sv
design/instrClassify.sv
design/memAccess.sv
design/memWbReg.sv
design/memStage.sv
tests/memStageTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the memory stage testbench with Verilator.
# Exit status is nonzero when the build fails, the simulation
# aborts, or the log holds the fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=memStageSim

verilator --binary --timing --assert -j 0 \
    --top-module memStageTb \
    -f flist.f \
    -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

if ! grep -q "All checks passed" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0
